// File: common/sampler_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the sampling collector
// slot index is 3 bits wide, so at most eight units can be registered
// samples are 13 bits; FIFO words carry the slot index above the sample
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sampler_pkg;

  localparam int unit_pos_w = 8;
  localparam int sample_w   = 13;
  localparam int slot_idx_w = 3;

  // upper byte selects the block, lower byte the register
  typedef logic [15:0] addr_t;
  typedef logic [31:0] bus_data_t;

  typedef logic [unit_pos_w-1:0] unit_pos_t;
  typedef logic [sample_w-1:0]   sample_t;
  typedef logic [slot_idx_w-1:0] slot_idx_t;

  // {slot index, sample}
  typedef logic [slot_idx_w+sample_w-1:0] fifo_word_t;

  // position reported by an empty slot
  localparam unit_pos_t no_unit = 8'd255;

  // register offsets in the low address byte
  localparam logic [7:0] reg_new_unit = 8'd4;
  localparam logic [7:0] reg_command  = 8'd5;

  // command codes written to reg_command
  localparam bus_data_t cmd_start = 32'd1;
  localparam bus_data_t cmd_stop  = 32'd2;
  localparam bus_data_t cmd_clear = 32'd5;

  // one slot visit is fetch, fetch_wait, store, advance
  typedef enum logic [2:0] {
    idle,
    fetch,
    fetch_wait,
    store,
    advance
  } scan_state_t;

endpackage

// File: logic/cmd_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write-only command decoder, register read-back is not supported
// unit registration is refused while the scan runs or all slots are taken
// every output pulse is one cycle long and one cycle after the write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cmd_decoder #(
  parameter int position  = 242,
  parameter int num_slots = 8
) (
  input  logic                            clk,
  input  logic                            rst,
  input  sampler_pkg::addr_t              addr,
  input  sampler_pkg::bus_data_t          cmd_data,
  input  logic                            cs,
  input  logic                            wr,
  input  logic                            busy,
  output logic [num_slots-1:0]            slot_load,
  output sampler_pkg::unit_pos_t          load_pos,
  output logic [sampler_pkg::slot_idx_w:0] num_units,
  output logic                            start_pulse,
  output logic                            stop_pulse,
  output logic                            clear_pulse
);
  import sampler_pkg::*;

  logic accept;
  logic cmd_write;
  logic unit_write;

  // block is selected by the upper address byte
  assign accept     = cs && wr && (addr[15:8] == 8'(position));
  assign cmd_write  = accept && (addr[7:0] == reg_command);
  assign unit_write = accept && (addr[7:0] == reg_new_unit) && !busy &&
                      (num_units < num_slots);

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_load   <= '0;
      num_units   <= '0;
      start_pulse <= 1'b0;
      stop_pulse  <= 1'b0;
      clear_pulse <= 1'b0;
    end else begin
      slot_load   <= '0;
      start_pulse <= cmd_write && (cmd_data == cmd_start);
      stop_pulse  <= cmd_write && (cmd_data == cmd_stop);
      clear_pulse <= cmd_write && (cmd_data == cmd_clear);

      if (cmd_write && (cmd_data == cmd_clear)) begin
        num_units <= '0;
      end else if (unit_write) begin
        // next free slot is the one at the current count
        slot_load[num_units[slot_idx_w-1:0]] <= 1'b1;
        num_units <= num_units + 1'b1;
      end
    end
  end

  // new position travels with the load strobe
  always_ff @(posedge clk) begin
    if (unit_write) begin
      load_pos <= cmd_data[unit_pos_w-1:0];
    end
  end

  // count never passes the number of slots
  a_unit_limit: assert property (@(posedge clk) disable iff (rst)
    num_units <= num_slots);

endmodule

// File: collector/channel_slot.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one registered source unit
// an empty slot reports no_unit, last stored sample starts at zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module channel_slot (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load,
  input  sampler_pkg::unit_pos_t load_pos,
  input  logic                   clear,
  input  logic                   commit,
  input  sampler_pkg::sample_t   captured,
  output sampler_pkg::unit_pos_t unit_pos,
  output logic                   changed
);
  import sampler_pkg::*;

  sample_t last_sample;

  always_ff @(posedge clk) begin
    if (rst) begin
      unit_pos <= no_unit;
    end else if (clear) begin
      unit_pos <= no_unit;
    end else if (load) begin
      unit_pos <= load_pos;
    end
  end

  // clear and load both restart the history, so the first sample differs
  // unless it is zero
  always_ff @(posedge clk) begin
    if (rst) begin
      last_sample <= '0;
    end else if (clear || load) begin
      last_sample <= '0;
    end else if (commit) begin
      last_sample <= captured;
    end
  end

  // compared against the sequencer's shared capture register
  assign changed = (captured != last_sample);

endmodule

// File: collector/scan_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// walks the registered slots, four cycles per visit
// source must hold sample_data stable from the second strobe cycle
// stop and clear take effect at the end of the current visit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module scan_sequencer #(
  parameter int num_slots = 8
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             start_pulse,
  input  logic                             stop_pulse,
  input  logic                             clear_pulse,
  input  logic [sampler_pkg::slot_idx_w:0] num_units,
  input  sampler_pkg::sample_t             sample_data,
  input  sampler_pkg::unit_pos_t           slot_pos [num_slots],
  input  logic [num_slots-1:0]             slot_changed,
  output logic                             busy,
  output sampler_pkg::slot_idx_t           cur_idx,
  output sampler_pkg::sample_t             captured,
  output logic [num_slots-1:0]             commit,
  output logic                             sample_strobe,
  output sampler_pkg::unit_pos_t           channel_select,
  output logic                             push,
  output sampler_pkg::fifo_word_t          push_word
);
  import sampler_pkg::*;

  scan_state_t state;
  logic        stop_pending;
  logic        clear_pending;
  logic        halt;
  logic        last_slot;
  logic        store_word;

  // a request arriving in the advance cycle itself still counts
  assign halt      = stop_pending || clear_pending || stop_pulse || clear_pulse;
  assign last_slot = ({1'b0, cur_idx} == num_units - 1'b1);

  // slots are being emptied, their history is gone
  assign store_word = (state == advance) && slot_changed[cur_idx] &&
                      !clear_pending && !clear_pulse;

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= idle;
      cur_idx       <= '0;
      stop_pending  <= 1'b0;
      clear_pending <= 1'b0;
    end else begin
      // hold requests until the visit ends
      if (busy && state != advance) begin
        if (stop_pulse) begin
          stop_pending <= 1'b1;
        end
        if (clear_pulse) begin
          clear_pending <= 1'b1;
        end
      end

      case (state)
        idle: begin
          stop_pending  <= 1'b0;
          clear_pending <= 1'b0;
          if (clear_pulse) begin
            cur_idx <= '0;
          end else if (start_pulse && num_units != '0) begin
            cur_idx <= '0;
            state   <= fetch;
          end
        end
        fetch:      state <= fetch_wait;
        fetch_wait: state <= store;
        store:      state <= advance;
        advance: begin
          if (halt) begin
            state         <= idle;
            cur_idx       <= '0;
            stop_pending  <= 1'b0;
            clear_pending <= 1'b0;
          end else begin
            state   <= fetch;
            cur_idx <= last_slot ? '0 : cur_idx + 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // sample is registered on entry to store
  always_ff @(posedge clk) begin
    if (state == fetch_wait) begin
      captured <= sample_data;
    end
  end

  always_comb begin
    commit = '0;
    commit[cur_idx] = store_word;
  end

  assign busy           = (state != idle);
  assign sample_strobe  = (state == fetch) || (state == fetch_wait);
  // empty slots report no_unit, so this idles at no_unit with no units
  assign channel_select = slot_pos[cur_idx];
  assign push           = store_word;
  assign push_word      = {cur_idx, captured};

  // a visit only ever begins on a registered unit
  a_strobe_target: assert property (@(posedge clk) disable iff (rst)
    $rose(sample_strobe) |-> channel_select != no_unit);

  // words only come from slots that are still registered
  a_push_target: assert property (@(posedge clk) disable iff (rst)
    push |-> channel_select != no_unit);

endmodule

// File: logic/sample_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fifo_depth must be a power of two, at least 2
// push when full is dropped and sets overflow until rst
// read data and valid appear one cycle after rd_strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module sample_fifo #(
  parameter int fifo_depth = 16
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    push,
  input  sampler_pkg::fifo_word_t push_word,
  input  logic                    rd_strobe,
  output sampler_pkg::fifo_word_t sample_out,
  output logic                    sample_valid,
  output logic                    fifo_empty,
  output logic                    overflow
);
  import sampler_pkg::*;

  localparam int aw = $clog2(fifo_depth);

  fifo_word_t   mem [fifo_depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [aw:0]   count;
  logic          full;
  logic          do_push;
  logic          do_pop;

  assign full       = (count == (aw + 1)'(fifo_depth));
  assign fifo_empty = (count == '0);
  assign do_push    = push && !full;
  assign do_pop     = rd_strobe && !fifo_empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      sample_valid <= 1'b0;
      overflow     <= 1'b0;
    end else begin
      sample_valid <= do_pop;
      if (push && full) begin
        overflow <= 1'b1;
      end
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // pointers wrap naturally at the power-of-two depth
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_word;
    end
    if (do_pop) begin
      sample_out <= mem[rd_ptr];
    end
  end

  a_fill_bound: assert property (@(posedge clk) disable iff (rst)
    count <= (aw + 1)'(fifo_depth));

endmodule

// File: logic/sample_collector.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sampling collector on the command bus, write-only registers
// num_slots is 1 to 8, fifo_depth a power of two
// no back-pressure anywhere, a full FIFO drops new words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module sample_collector #(
  parameter int position   = 242,
  parameter int num_slots  = 8,
  parameter int fifo_depth = 16
) (
  input  logic                    clk,
  input  logic                    rst,
  input  sampler_pkg::addr_t      addr,
  input  sampler_pkg::bus_data_t  cmd_data,
  input  logic                    cs,
  input  logic                    wr,
  input  sampler_pkg::sample_t    sample_data,
  output logic                    sample_strobe,
  output sampler_pkg::unit_pos_t  channel_select,
  input  logic                    rd_strobe,
  output sampler_pkg::fifo_word_t sample_out,
  output logic                    sample_valid,
  output logic                    fifo_empty,
  output logic                    overflow
);
  import sampler_pkg::*;

  logic                  busy;
  logic [num_slots-1:0]  slot_load;
  unit_pos_t             load_pos;
  logic [slot_idx_w:0]   num_units;
  logic                  start_pulse;
  logic                  stop_pulse;
  logic                  clear_pulse;
  unit_pos_t             slot_pos [num_slots];
  logic [num_slots-1:0]  slot_changed;
  logic [num_slots-1:0]  commit;
  sample_t               captured;
  logic                  push;
  fifo_word_t            push_word;

  cmd_decoder #(
    .position  (position),
    .num_slots (num_slots)
  ) i_cmd_decoder (
    .clk         (clk),
    .rst         (rst),
    .addr        (addr),
    .cmd_data    (cmd_data),
    .cs          (cs),
    .wr          (wr),
    .busy        (busy),
    .slot_load   (slot_load),
    .load_pos    (load_pos),
    .num_units   (num_units),
    .start_pulse (start_pulse),
    .stop_pulse  (stop_pulse),
    .clear_pulse (clear_pulse)
  );

  for (genvar i = 0; i < num_slots; i++) begin : g_slot
    channel_slot i_channel_slot (
      .clk      (clk),
      .rst      (rst),
      .load     (slot_load[i]),
      .load_pos (load_pos),
      .clear    (clear_pulse),
      .commit   (commit[i]),
      .captured (captured),
      .unit_pos (slot_pos[i]),
      .changed  (slot_changed[i])
    );
  end

  // slot index is carried in push_word, the separate index stays internal
  scan_sequencer #(
    .num_slots (num_slots)
  ) i_scan_sequencer (
    .clk            (clk),
    .rst            (rst),
    .start_pulse    (start_pulse),
    .stop_pulse     (stop_pulse),
    .clear_pulse    (clear_pulse),
    .num_units      (num_units),
    .sample_data    (sample_data),
    .slot_pos       (slot_pos),
    .slot_changed   (slot_changed),
    .busy           (busy),
    .cur_idx        (),
    .captured       (captured),
    .commit         (commit),
    .sample_strobe  (sample_strobe),
    .channel_select (channel_select),
    .push           (push),
    .push_word      (push_word)
  );

  sample_fifo #(
    .fifo_depth (fifo_depth)
  ) i_sample_fifo (
    .clk          (clk),
    .rst          (rst),
    .push         (push),
    .push_word    (push_word),
    .rd_strobe    (rd_strobe),
    .sample_out   (sample_out),
    .sample_valid (sample_valid),
    .fifo_empty   (fifo_empty),
    .overflow     (overflow)
  );

endmodule

// File: verification/sample_collector_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the sampling collector with default parameters
// source model answers strobes from a table indexed by channel_select
// run is limited by a cycle counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module sample_collector_tb;
  import sampler_pkg::*;

  localparam int position   = 242;
  localparam int num_slots  = 8;
  localparam int fifo_depth = 16;
  // about 1000 cycles of tests, with plenty of margin
  localparam int max_cycles = 4000;

  localparam addr_t unit_addr = {8'(position), reg_new_unit};
  localparam addr_t cmd_addr  = {8'(position), reg_command};

  logic       clk = 1'b0;
  logic       rst;
  addr_t      addr;
  bus_data_t  cmd_data;
  logic       cs;
  logic       wr;
  sample_t    sample_data;
  logic       sample_strobe;
  unit_pos_t  channel_select;
  logic       rd_strobe;
  fifo_word_t sample_out;
  logic       sample_valid;
  logic       fifo_empty;
  logic       overflow;

  // source table and scoreboard
  sample_t    src_val [256];
  unit_pos_t  units [num_slots];
  sample_t    last_exp [num_slots];
  int         unit_count;
  fifo_word_t expected_q [$];

  int      errors;
  int      test_base;
  int      tests_run;
  int      tests_failed;
  int      cycles;
  int      strobe_count;
  int      strobe_mark;
  int      model_slot;
  sample_t model_val;
  logic    strobe_prev;
  logic    valid_exp;

  sample_collector #(
    .position   (position),
    .num_slots  (num_slots),
    .fifo_depth (fifo_depth)
  ) i_sample_collector (
    .clk            (clk),
    .rst            (rst),
    .addr           (addr),
    .cmd_data       (cmd_data),
    .cs             (cs),
    .wr             (wr),
    .sample_data    (sample_data),
    .sample_strobe  (sample_strobe),
    .channel_select (channel_select),
    .rd_strobe      (rd_strobe),
    .sample_out     (sample_out),
    .sample_valid   (sample_valid),
    .fifo_empty     (fifo_empty),
    .overflow       (overflow)
  );

  always #5 clk = ~clk;

  task automatic expect_equal(string name, logic [31:0] actual, logic [31:0] expected);
    assert (actual == expected) else begin
      errors++;
      $display("** Error at time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic note_failure(string what);
    errors++;
    $display("failure at time %0t: %s", $time, what);
  endtask

  function automatic int slot_for(unit_pos_t pos);
    for (int i = 0; i < unit_count; i++) begin
      if (units[i] == pos) begin
        return i;
      end
    end
    return -1;
  endfunction

  // nonzero, and never equal to the previous value
  function automatic sample_t new_value(sample_t old);
    sample_t v;
    v = sample_t'($urandom % 8191) + 1'b1;
    if (v == old) begin
      v = (old == 13'd8191) ? 13'd1 : old + 1'b1;
    end
    return v;
  endfunction

  // tasks start and end 1 time unit after a rising edge
  task automatic run_cycles(int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic bus_write(addr_t a, bus_data_t d);
    addr     = a;
    cmd_data = d;
    cs       = 1'b1;
    wr       = 1'b1;
    run_cycles(1);
    cs = 1'b0;
    wr = 1'b0;
  endtask

  task automatic register_unit(unit_pos_t pos);
    bus_write(unit_addr, bus_data_t'(pos));
    units[unit_count]    = pos;
    last_exp[unit_count] = '0;
    unit_count++;
  endtask

  task automatic wait_not_empty();
    int n;
    n = 0;
    while (fifo_empty && n < 200) begin
      run_cycles(1);
      n++;
    end
    if (fifo_empty) begin
      note_failure("no word reached the FIFO");
    end
  endtask

  // read one word and compare it with the next expected word
  task automatic read_word(output fifo_word_t w);
    rd_strobe = 1'b1;
    run_cycles(1);
    rd_strobe = 1'b0;
    w = sample_out;
    if (!sample_valid) begin
      note_failure("sample_valid missing after rd_strobe");
    end else if (expected_q.size() == 0) begin
      note_failure("word read while none was expected");
    end else begin
      expect_equal("sample_out", w, expected_q.pop_front());
    end
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (errors > test_base) begin
      tests_failed++;
      $display("test %0d %s: fail with %0d errors", tests_run, name, errors - test_base);
    end else begin
      $display("test %0d %s: pass", tests_run, name);
    end
    test_base = errors;
  endtask

  // source model, strobe state is read before this edge updates it
  always @(posedge clk) begin
    if (rst) begin
      strobe_prev <= 1'b0;
    end else begin
      strobe_prev <= sample_strobe;
      if (sample_strobe && !strobe_prev) begin
        strobe_count++;
        model_slot = slot_for(channel_select);
        if (model_slot < 0) begin
          note_failure($sformatf("strobe for unregistered position %0d", channel_select));
        end else begin
          // the value seen at the strobe is the one the source returns
          model_val = src_val[channel_select];
          if (model_val != last_exp[model_slot]) begin
            expected_q.push_back({slot_idx_t'(model_slot), model_val});
            last_exp[model_slot] = model_val;
          end
          #1 sample_data = model_val;
        end
      end
    end
  end

  // read timing and strobe target
  always @(posedge clk) begin
    if (rst) begin
      valid_exp <= 1'b0;
    end else begin
      expect_equal("sample_valid", sample_valid, valid_exp);
      assert (!sample_strobe || channel_select != no_unit) else begin
        note_failure("sample_strobe raised with no unit selected");
      end
      // every read issued here expects a word
      valid_exp <= rd_strobe;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run exceeded %0d cycles", max_cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    fifo_word_t w;
    void'($urandom(19988));
    rst         = 1'b1;
    addr        = '0;
    cmd_data    = '0;
    cs          = 1'b0;
    wr          = 1'b0;
    rd_strobe   = 1'b0;
    sample_data = '0;
    cycles      = 0;
    unit_count  = 0;
    foreach (src_val[i]) begin
      src_val[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;

    run_cycles(1);
    expect_equal("sample_strobe", sample_strobe, 1'b0);
    expect_equal("channel_select", channel_select, no_unit);
    expect_equal("fifo_empty", fifo_empty, 1'b1);
    expect_equal("overflow", overflow, 1'b0);
    finish_test("reset state");

    register_unit(8'd17);
    register_unit(8'd42);
    register_unit(8'd200);
    for (int i = 0; i < 3; i++) begin
      src_val[units[i]] = new_value('0);
    end
    bus_write(cmd_addr, cmd_start);
    for (int i = 0; i < 3; i++) begin
      wait_not_empty();
      read_word(w);
      expect_equal("slot index", w[15:13], i);
    end
    finish_test("first scan pass");

    // constant values give no new words
    strobe_mark = strobe_count;
    run_cycles(120);
    expect_equal("fifo_empty", fifo_empty, 1'b1);
    if (strobe_count - strobe_mark < 27) begin
      note_failure("scan did not keep running with constant values");
    end
    src_val[units[1]] = new_value(src_val[units[1]]);
    wait_not_empty();
    read_word(w);
    expect_equal("slot index", w[15:13], 1);
    run_cycles(24);
    expect_equal("fifo_empty", fifo_empty, 1'b1);
    finish_test("change detection");

    // registration while scanning is refused
    bus_write(unit_addr, 32'd77);
    run_cycles(24);
    bus_write(cmd_addr, cmd_stop);
    run_cycles(6);
    strobe_mark = strobe_count;
    run_cycles(24);
    expect_equal("strobe count after stop", strobe_count, strobe_mark);
    bus_write({8'h11, reg_new_unit}, 32'd88);
    bus_write({8'h11, reg_command}, cmd_start);
    run_cycles(24);
    expect_equal("strobe count after foreign write", strobe_count, strobe_mark);
    bus_write(cmd_addr, cmd_start);
    src_val[units[2]] = new_value(src_val[units[2]]);
    wait_not_empty();
    bus_write(cmd_addr, cmd_stop);
    run_cycles(30);
    finish_test("ignored writes and stop");

    // the word left in the FIFO must survive the clear
    bus_write(cmd_addr, cmd_clear);
    unit_count = 0;
    run_cycles(2);
    expect_equal("channel_select", channel_select, no_unit);
    strobe_mark = strobe_count;
    bus_write(cmd_addr, cmd_start);
    run_cycles(24);
    expect_equal("strobe count after clear", strobe_count, strobe_mark);
    expect_equal("fifo_empty", fifo_empty, 1'b0);
    read_word(w);
    expect_equal("fifo_empty", fifo_empty, 1'b1);
    finish_test("clear");

    register_unit(8'd5);
    register_unit(8'd99);
    register_unit(8'd150);
    for (int i = 0; i < 3; i++) begin
      src_val[units[i]] = new_value('0);
    end
    bus_write(cmd_addr, cmd_start);
    repeat (9) begin
      run_cycles(12);
      for (int i = 0; i < 3; i++) begin
        src_val[units[i]] = new_value(src_val[units[i]]);
      end
    end
    expect_equal("overflow", overflow, 1'b1);
    bus_write(cmd_addr, cmd_stop);
    run_cycles(10);
    if (expected_q.size() < fifo_depth) begin
      note_failure("fewer words expected than the FIFO holds");
    end
    for (int i = 0; i < fifo_depth; i++) begin
      read_word(w);
    end
    expect_equal("fifo_empty", fifo_empty, 1'b1);
    expected_q.delete();
    finish_test("overflow");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: sample_collector.f
common/sampler_pkg.sv
logic/cmd_decoder.sv
collector/channel_slot.sv
collector/scan_sequencer.sv
logic/sample_fifo.sv
logic/sample_collector.sv
verification/sample_collector_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the sample_collector testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sample_collector.f \
  --top-module sample_collector_tb \
  --Mdir obj_dir

./obj_dir/Vsample_collector_tb > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi

echo "simulation passed"
